// File: source/egr_tag_pkg.sv
/*
 * Shared types and sizing for the egress tag manager.
 * Every block refers to these by scoped name.
 */

`default_nettype none

package egr_tag_pkg;

  // --------------------
  // Sizing
  // --------------------

  // Egress ports and traffic classes
  localparam int num_ports  = 4;
  localparam int num_tcs    = 2;

  // One virtual output queue per port and class
  localparam int num_queues = num_ports * num_tcs;

  // Tags held per queue
  localparam int queue_depth = 4;

  // Field widths
  localparam int qid_w   = $clog2(num_queues);
  localparam int port_w  = $clog2(num_ports);
  localparam int tc_w    = $clog2(num_tcs);
  localparam int len_w   = 7;
  localparam int ptr_w   = 16;
  localparam int qptr_w  = $clog2(queue_depth);
  localparam int seg_w   = 10;
  localparam int drop_w  = 16;

  // --------------------
  // Types
  // --------------------

  // Queue number, port in the upper bits, class in bit 0
  typedef logic [qid_w-1:0] qid_t;

  // Tag as carried on the ring slot and handed to the read controller
  typedef struct packed {
    logic              valid;
    logic [port_w-1:0] port;
    logic [tc_w-1:0]   tc;
    // Segment length in 64B units
    logic [len_w-1:0]  length;
    // Buffer pointer of the first segment
    logic [ptr_w-1:0]  ptr;
    logic              eop;
  } egr_tag_t;

  // Update strobe to the egress scheduler
  typedef struct packed {
    logic             valid;
    qid_t             qid;
    logic [len_w-1:0] length;
  } egr_update_t;

  // Sum of lengths held in one queue, up to 4 x 127
  typedef logic [seg_w-1:0] seg_count_t;

  // Tags dropped on a full queue
  typedef logic [drop_w-1:0] drop_count_t;

endpackage

`default_nettype wire

// File: source/tag_ring_rx.sv
/*
 * Ring slot receiver. Registers the incoming tag, maps it to a queue
 * and either enqueues it or drops it when that queue is full.
 */

`default_nettype none

module tag_ring_rx (
  input  wire logic                            clk,
  input  wire logic                            rst_n,
  input  wire egr_tag_pkg::egr_tag_t           ring_tag,
  input  wire logic [egr_tag_pkg::num_queues-1:0] queue_full,
  output logic                                 enq,
  output egr_tag_pkg::qid_t                    enq_qid,
  output egr_tag_pkg::egr_tag_t                enq_tag,
  output egr_tag_pkg::drop_count_t             drop_count
);

  // Slot register, valid kept apart from the fields
  logic                  slot_vld;
  egr_tag_pkg::egr_tag_t slot_q;
  logic                  drop;

  // --------------------
  // Slot capture
  // --------------------

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      slot_vld <= 1'b0;
    end else begin
      slot_vld <= ring_tag.valid;
    end
  end

  always_ff @(posedge clk) begin
    slot_q <= ring_tag;
  end

  // --------------------
  // Accept or drop
  // --------------------

  // Port in the upper bits, class below
  assign enq_qid = {slot_q.port, slot_q.tc};

  // Fullness is checked against the buffer as it stands now
  assign drop = slot_vld & queue_full[enq_qid];
  assign enq  = slot_vld & ~queue_full[enq_qid];

  always_comb begin
    enq_tag       = slot_q;
    enq_tag.valid = slot_vld;
  end

  // Counts every dropped tag, wraps at the top
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      drop_count <= '0;
    end else if (drop) begin
      drop_count <= drop_count + 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: source/tag_queue_buf.sv
/*
 * Tag storage for all virtual output queues. Each queue is a small
 * circular FIFO; enqueue and dequeue strobes are taken as given.
 */

`default_nettype none

module tag_queue_buf (
  input  wire logic                  clk,
  input  wire logic                  rst_n,
  input  wire logic                  enq,
  input  wire egr_tag_pkg::qid_t     enq_qid,
  input  wire egr_tag_pkg::egr_tag_t enq_tag,
  input  wire logic                  deq,
  input  wire egr_tag_pkg::qid_t     deq_qid,
  output egr_tag_pkg::egr_tag_t      head_tag,
  output logic [egr_tag_pkg::num_queues-1:0] queue_valid,
  output logic [egr_tag_pkg::num_queues-1:0] queue_full
);

  localparam int nq = egr_tag_pkg::num_queues;
  localparam int pw = egr_tag_pkg::qptr_w;

  // Tag slots per queue
  egr_tag_pkg::egr_tag_t mem [nq][egr_tag_pkg::queue_depth];

  // Read and write pointers
  logic [nq-1:0][pw-1:0] head_ptr;
  logic [nq-1:0][pw-1:0] tail_ptr;

  // Occupancy, one bit wider than the pointers
  logic [nq-1:0][pw:0]   occ;

  // Per queue strobe decode
  logic [nq-1:0]         enq_hit;
  logic [nq-1:0]         deq_hit;

  // --------------------
  // Strobe decode
  // --------------------

  always_comb begin
    for (int q = 0; q < nq; q++) begin
      enq_hit[q] = enq && (enq_qid == egr_tag_pkg::qid_t'(q));
      deq_hit[q] = deq && (deq_qid == egr_tag_pkg::qid_t'(q));
    end
  end

  // --------------------
  // Pointers and occupancy
  // --------------------

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      head_ptr <= '0;
      tail_ptr <= '0;
      occ      <= '0;
    end else begin
      for (int q = 0; q < nq; q++) begin
        if (enq_hit[q]) begin
          tail_ptr[q] <= tail_ptr[q] + 1'b1;
        end
        if (deq_hit[q]) begin
          head_ptr[q] <= head_ptr[q] + 1'b1;
        end
        // Push and pop together leave the count alone
        if (enq_hit[q] && !deq_hit[q]) begin
          occ[q] <= occ[q] + 1'b1;
        end else if (deq_hit[q] && !enq_hit[q]) begin
          occ[q] <= occ[q] - 1'b1;
        end
      end
    end
  end

  // --------------------
  // Storage
  // --------------------

  // Write at the tail of the addressed queue
  always_ff @(posedge clk) begin
    if (enq) begin
      mem[enq_qid][tail_ptr[enq_qid]] <= enq_tag;
    end
  end

  // Head of the queue being popped, same cycle
  assign head_tag = mem[deq_qid][head_ptr[deq_qid]];

  // --------------------
  // Status
  // --------------------

  always_comb begin
    for (int q = 0; q < nq; q++) begin
      queue_valid[q] = (occ[q] != '0);
      queue_full[q]  = (occ[q] == (pw + 1)'(egr_tag_pkg::queue_depth));
    end
  end

endmodule

`default_nettype wire

// File: source/queue_status.sv
/*
 * Per queue segment totals and the update strobe to the scheduler.
 * Counters follow every enqueue and dequeue in the same cycle.
 */

`default_nettype none

module queue_status (
  input  wire logic                                clk,
  input  wire logic                                rst_n,
  input  wire logic                                enq,
  input  wire egr_tag_pkg::qid_t                   enq_qid,
  input  wire logic [egr_tag_pkg::len_w-1:0]       enq_length,
  input  wire logic                                deq,
  input  wire egr_tag_pkg::qid_t                   deq_qid,
  input  wire logic [egr_tag_pkg::len_w-1:0]       deq_length,
  output egr_tag_pkg::seg_count_t [egr_tag_pkg::num_queues-1:0] seg_count,
  output egr_tag_pkg::egr_update_t                 pfs_update
);

  localparam int nq = egr_tag_pkg::num_queues;

  // Lengths widened to counter size
  egr_tag_pkg::seg_count_t add_len;
  egr_tag_pkg::seg_count_t sub_len;

  // Update register
  logic                            upd_vld;
  egr_tag_pkg::qid_t               upd_qid;
  logic [egr_tag_pkg::len_w-1:0]   upd_len;

  assign add_len = egr_tag_pkg::seg_count_t'(enq_length);
  assign sub_len = egr_tag_pkg::seg_count_t'(deq_length);

  // --------------------
  // Segment counters
  // --------------------

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      seg_count <= '0;
    end else begin
      for (int q = 0; q < nq; q++) begin
        // Add and subtract can both hit one queue
        seg_count[q] <= seg_count[q]
          + ((enq && enq_qid == egr_tag_pkg::qid_t'(q)) ? add_len : '0)
          - ((deq && deq_qid == egr_tag_pkg::qid_t'(q)) ? sub_len : '0);
      end
    end
  end

  // --------------------
  // Scheduler update
  // --------------------

  // One cycle pulse per accepted tag
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      upd_vld <= 1'b0;
    end else begin
      upd_vld <= enq;
    end
  end

  always_ff @(posedge clk) begin
    upd_qid <= enq_qid;
    upd_len <= enq_length;
  end

  assign pfs_update = '{valid: upd_vld, qid: upd_qid, length: upd_len};

endmodule

`default_nettype wire

// File: source/tag_dispatch.sv
/*
 * Pop handling. Checks the popped queue, dequeues its head and hands
 * the tag to the read controller one cycle later, or flags an error.
 */

`default_nettype none

module tag_dispatch (
  input  wire logic                               clk,
  input  wire logic                               rst_n,
  input  wire logic                               pop,
  input  wire egr_tag_pkg::qid_t                  pop_qid,
  input  wire logic [egr_tag_pkg::num_queues-1:0] queue_valid,
  input  wire egr_tag_pkg::egr_tag_t              head_tag,
  output logic                                    deq,
  output egr_tag_pkg::qid_t                       deq_qid,
  output egr_tag_pkg::egr_tag_t                   prc_tag,
  output logic                                    pop_err
);

  // Hand-off register
  logic                  prc_vld;
  egr_tag_pkg::egr_tag_t prc_q;

  // --------------------
  // Pop decode
  // --------------------

  // Only a queue already holding tags is popped
  assign deq     = pop & queue_valid[pop_qid];
  assign deq_qid = pop_qid;

  // --------------------
  // Hand-off
  // --------------------

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      prc_vld <= 1'b0;
      pop_err <= 1'b0;
    end else begin
      prc_vld <= deq;
      // Pop of an empty queue
      pop_err <= pop & ~queue_valid[pop_qid];
    end
  end

  always_ff @(posedge clk) begin
    if (deq) begin
      prc_q <= head_tag;
    end
  end

  always_comb begin
    prc_tag       = prc_q;
    prc_tag.valid = prc_vld;
  end

endmodule

`default_nettype wire

// File: source/tmu.sv
/*
 * Egress tag manager top. Ring receiver, queue buffer, segment
 * status and pop dispatch, wired together.
 */

`default_nettype none

module tmu (
  input  wire logic                               clk,
  input  wire logic                               rst_n,
  input  wire egr_tag_pkg::egr_tag_t              ring_tag,
  input  wire logic                               pop,
  input  wire egr_tag_pkg::qid_t                  pop_qid,
  output logic [egr_tag_pkg::num_queues-1:0]      queue_valid,
  output egr_tag_pkg::seg_count_t [egr_tag_pkg::num_queues-1:0] seg_count,
  output egr_tag_pkg::egr_update_t                pfs_update,
  output egr_tag_pkg::egr_tag_t                   prc_tag,
  output logic                                    pop_err,
  output egr_tag_pkg::drop_count_t                drop_count
);

  // Enqueue side
  logic                                  enq;
  egr_tag_pkg::qid_t                     enq_qid;
  egr_tag_pkg::egr_tag_t                 enq_tag;
  logic [egr_tag_pkg::num_queues-1:0]    queue_full;

  // Dequeue side
  logic                                  deq;
  egr_tag_pkg::qid_t                     deq_qid;
  egr_tag_pkg::egr_tag_t                 head_tag;

  // --------------------
  // Blocks
  // --------------------

  tag_ring_rx u_ring_rx (
    .clk        (clk),
    .rst_n      (rst_n),
    .ring_tag   (ring_tag),
    .queue_full (queue_full),
    .enq        (enq),
    .enq_qid    (enq_qid),
    .enq_tag    (enq_tag),
    .drop_count (drop_count)
  );

  tag_queue_buf u_queue_buf (
    .clk         (clk),
    .rst_n       (rst_n),
    .enq         (enq),
    .enq_qid     (enq_qid),
    .enq_tag     (enq_tag),
    .deq         (deq),
    .deq_qid     (deq_qid),
    .head_tag    (head_tag),
    .queue_valid (queue_valid),
    .queue_full  (queue_full)
  );

  // Head length goes out with the dequeue strobe
  queue_status u_status (
    .clk        (clk),
    .rst_n      (rst_n),
    .enq        (enq),
    .enq_qid    (enq_qid),
    .enq_length (enq_tag.length),
    .deq        (deq),
    .deq_qid    (deq_qid),
    .deq_length (head_tag.length),
    .seg_count  (seg_count),
    .pfs_update (pfs_update)
  );

  tag_dispatch u_dispatch (
    .clk         (clk),
    .rst_n       (rst_n),
    .pop         (pop),
    .pop_qid     (pop_qid),
    .queue_valid (queue_valid),
    .head_tag    (head_tag),
    .deq         (deq),
    .deq_qid     (deq_qid),
    .prc_tag     (prc_tag),
    .pop_err     (pop_err)
  );

endmodule

`default_nettype wire

// File: verification/tmu_tb.sv
/*
 * Testbench for the egress tag manager. Reads one line per clock cycle
 * from the tests file, drives ring slot and pop inputs, and checks the
 * registered outputs just before the next rising edge.
 */

`default_nettype none

module tmu_tb;

  localparam int clk_period     = 40;
  localparam int max_cycles     = 200;
  localparam int num_fields     = 18;
  localparam int min_data_lines = 24;

  // Expected outputs of one cycle
  typedef struct packed {
    logic [egr_tag_pkg::num_queues-1:0] queue_valid;
    logic                               prc_valid;
    logic [egr_tag_pkg::ptr_w-1:0]      prc_ptr;
    logic                               pop_err;
    egr_tag_pkg::drop_count_t           drop_count;
    egr_tag_pkg::qid_t                  seg_qid;
    egr_tag_pkg::seg_count_t            seg_count;
    logic                               upd_valid;
    egr_tag_pkg::qid_t                  upd_qid;
    logic [egr_tag_pkg::len_w-1:0]      upd_length;
  } expect_t;

  // DUT ports
  logic                                                 clk;
  logic                                                 rst_n;
  egr_tag_pkg::egr_tag_t                                ring_tag;
  logic                                                 pop;
  egr_tag_pkg::qid_t                                    pop_qid;
  logic [egr_tag_pkg::num_queues-1:0]                   queue_valid;
  egr_tag_pkg::seg_count_t [egr_tag_pkg::num_queues-1:0] seg_count;
  egr_tag_pkg::egr_update_t                             pfs_update;
  egr_tag_pkg::egr_tag_t                                prc_tag;
  logic                                                 pop_err;
  egr_tag_pkg::drop_count_t                             drop_count;

  // File reading state
  int          fd;
  int          code;
  int          cycle;
  int          file_line;
  int          data_lines;
  int          value_errors;
  int          other_errors;
  string       text;
  logic [31:0] fld [num_fields];
  expect_t     exp_now;

  tmu uut (
    .clk         (clk),
    .rst_n       (rst_n),
    .ring_tag    (ring_tag),
    .pop         (pop),
    .pop_qid     (pop_qid),
    .queue_valid (queue_valid),
    .seg_count   (seg_count),
    .pfs_update  (pfs_update),
    .prc_tag     (prc_tag),
    .pop_err     (pop_err),
    .drop_count  (drop_count)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  // --------------------
  // Helpers
  // --------------------

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] want);
    $display("ERROR %s: got 0x%0h, expected 0x%0h, tests line %0d",
             name, got, want, file_line);
    value_errors++;
  endtask

  // Ring slot fields, then pop strobe and queue
  task automatic apply_stimulus();
    ring_tag.valid  = fld[0][0];
    ring_tag.port   = fld[1][egr_tag_pkg::port_w-1:0];
    ring_tag.tc     = fld[2][egr_tag_pkg::tc_w-1:0];
    ring_tag.length = fld[3][egr_tag_pkg::len_w-1:0];
    ring_tag.ptr    = fld[4][egr_tag_pkg::ptr_w-1:0];
    ring_tag.eop    = fld[5][0];
    pop             = fld[6][0];
    pop_qid         = fld[7][egr_tag_pkg::qid_w-1:0];
  endtask

  task automatic load_expected();
    exp_now.queue_valid = fld[8][egr_tag_pkg::num_queues-1:0];
    exp_now.prc_valid   = fld[9][0];
    exp_now.prc_ptr     = fld[10][egr_tag_pkg::ptr_w-1:0];
    exp_now.pop_err     = fld[11][0];
    exp_now.drop_count  = fld[12][egr_tag_pkg::drop_w-1:0];
    exp_now.seg_qid     = fld[13][egr_tag_pkg::qid_w-1:0];
    exp_now.seg_count   = fld[14][egr_tag_pkg::seg_w-1:0];
    exp_now.upd_valid   = fld[15][0];
    exp_now.upd_qid     = fld[16][egr_tag_pkg::qid_w-1:0];
    exp_now.upd_length  = fld[17][egr_tag_pkg::len_w-1:0];
  endtask

  task automatic check_outputs(input expect_t exp);
    assert (queue_valid == exp.queue_valid)
      else report_mismatch("queue_valid", 32'(queue_valid), 32'(exp.queue_valid));
    assert (prc_tag.valid == exp.prc_valid)
      else report_mismatch("prc_tag.valid", 32'(prc_tag.valid), 32'(exp.prc_valid));
    // Pointer only means something on a hand-off
    if (exp.prc_valid) begin
      assert (prc_tag.ptr == exp.prc_ptr)
        else report_mismatch("prc_tag.ptr", 32'(prc_tag.ptr), 32'(exp.prc_ptr));
    end
    assert (pop_err == exp.pop_err)
      else report_mismatch("pop_err", 32'(pop_err), 32'(exp.pop_err));
    assert (drop_count == exp.drop_count)
      else report_mismatch("drop_count", 32'(drop_count), 32'(exp.drop_count));
    assert (seg_count[exp.seg_qid] == exp.seg_count)
      else report_mismatch("seg_count", 32'(seg_count[exp.seg_qid]), 32'(exp.seg_count));
    assert (pfs_update.valid == exp.upd_valid)
      else report_mismatch("pfs_update.valid", 32'(pfs_update.valid), 32'(exp.upd_valid));
    if (exp.upd_valid) begin
      assert (pfs_update.qid == exp.upd_qid)
        else report_mismatch("pfs_update.qid", 32'(pfs_update.qid), 32'(exp.upd_qid));
      assert (pfs_update.length == exp.upd_length)
        else report_mismatch("pfs_update.length", 32'(pfs_update.length),
                             32'(exp.upd_length));
    end
  endtask

  // --------------------
  // Main sequence
  // --------------------

  initial begin
    rst_n        = 1'b0;
    ring_tag     = '0;
    pop          = 1'b0;
    pop_qid      = '0;
    cycle        = 0;
    file_line    = 0;
    data_lines   = 0;
    value_errors = 0;
    other_errors = 0;

    repeat (4) @(posedge clk);
    #2;
    rst_n = 1'b1;

    fd = $fopen("verification/tmu_tests.txt", "r");
    if (fd == 0) begin
      $display("Could not open verification/tmu_tests.txt, no stimulus was applied");
      other_errors++;
    end else begin
      // One data line per cycle, first one lands in the reset state
      while (!$feof(fd) && cycle < max_cycles) begin
        cycle++;
        code = $fgets(text, fd);
        if (code > 1 && text.getc(0) != "#") begin
          file_line++;
          code = $sscanf(text, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                         fld[0], fld[1], fld[2], fld[3], fld[4], fld[5], fld[6],
                         fld[7], fld[8], fld[9], fld[10], fld[11], fld[12], fld[13],
                         fld[14], fld[15], fld[16], fld[17]);
          if (code != num_fields) begin
            $display("Tests line %0d has %0d fields instead of %0d, line skipped",
                     file_line, code, num_fields);
            other_errors++;
          end else begin
            data_lines++;
            apply_stimulus();
            load_expected();
            // Sample just ahead of the next edge
            #(clk_period - 4);
            check_outputs(exp_now);
            @(posedge clk);
            #2;
          end
        end else if (code > 1) begin
          file_line++;
        end
      end
      if (cycle >= max_cycles && !$feof(fd)) begin
        $display("Timeout: the tests file was not finished within %0d cycles", max_cycles);
        other_errors++;
      end
      $fclose(fd);
      if (data_lines < min_data_lines) begin
        $display("The tests file is too short: %0d data lines, at least %0d needed",
                 data_lines, min_data_lines);
        other_errors++;
      end
    end

    $display("Checked %0d cycles: %0d value errors, %0d other errors",
             data_lines, value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: src.f
source/egr_tag_pkg.sv
source/tag_ring_rx.sv
source/tag_queue_buf.sv
source/queue_status.sv
source/tag_dispatch.sv
source/tmu.sv
verification/tmu_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the egress tag manager testbench with Verilator and runs it.
# The run fails when the log holds the fail message.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tmu_tb -f src.f -o tmu_sim

./obj_dir/tmu_sim > sim.log 2>&1
cat sim.log

if grep -q "Regression failed" sim.log; then
  echo "Simulation reported failures, see sim.log"
  exit 1
fi

echo "Simulation log is clean"

// File: verification/tmu_tests.txt
# tag: v port tc len ptr eop | pop qid | expect: qvalid prc_v prc_ptr pop_err drops seg_q seg upd_v upd_q upd_len
# Hex fields, one line per clock cycle; expected values are the outputs at the end of that cycle
0 0 0 00 0000 0  0 0  00 0 0000 0 0000 5 000 0 0 00
1 2 1 10 a001 0  0 0  00 0 0000 0 0000 5 000 0 0 00
1 2 1 20 a002 0  0 0  00 0 0000 0 0000 5 000 0 0 00
1 2 1 05 a003 1  0 0  20 0 0000 0 0000 5 010 1 5 10
1 2 1 7f a004 1  0 0  20 0 0000 0 0000 5 030 1 5 20
1 2 1 33 a005 0  0 0  20 0 0000 0 0000 5 035 1 5 05
1 1 0 0a b001 1  0 0  20 0 0000 0 0000 5 0b4 1 5 7f
0 0 0 00 0000 0  1 0  20 0 0000 0 0001 5 0b4 0 0 00
0 0 0 00 0000 0  1 5  24 0 0000 1 0001 2 00a 1 2 0a
0 0 0 00 0000 0  1 5  24 1 a001 0 0001 5 0a4 0 0 00
1 2 1 02 a006 0  0 0  24 1 a002 0 0001 5 084 0 0 00
0 0 0 00 0000 0  1 5  24 0 0000 0 0001 5 084 0 0 00
0 0 0 00 0000 0  1 5  24 1 a003 0 0001 5 081 1 5 02
0 0 0 00 0000 0  1 5  24 1 a004 0 0001 5 002 0 0 00
0 0 0 00 0000 0  1 5  04 1 a006 0 0001 5 000 0 0 00
0 0 0 00 0000 0  1 2  04 0 0000 1 0001 2 00a 0 0 00
0 0 0 00 0000 0  0 0  00 1 b001 0 0001 2 000 0 0 00
1 3 1 11 c001 0  0 0  00 0 0000 0 0001 7 000 0 0 00
1 0 0 01 d001 1  0 0  00 0 0000 0 0001 7 000 0 0 00
0 1 1 44 ffff 1  0 0  80 0 0000 0 0001 7 011 1 7 11
0 0 0 00 0000 0  1 0  81 0 0000 0 0001 0 001 1 0 01
0 0 0 00 0000 0  1 7  80 1 d001 0 0001 0 000 0 0 00
0 0 0 00 0000 0  0 0  00 1 c001 0 0001 7 000 0 0 00
0 0 0 00 0000 0  0 0  00 0 0000 0 0001 3 000 0 0 00
